// File: lib_arbiter_pkg.sv
/*
 * Shared constants and enums for the 8x8 event-camera readout arbiter
 */
package lib_arbiter_pkg;

    localparam int lvl0_pixels     = 8;                      // Array side length
    localparam int polarity        = 2;                      // Bit 1 is ON, bit 0 is OFF
    localparam int lvl0_group_size = 4;                      // Group side length
    localparam int const0          = 2;                      // Groups per row or column
    localparam int num_groups0     = 4;                      // Total groups
    localparam int lvl0_add        = 2;                      // Address width inside a group
    localparam int full_add        = 3;                      // Full x or y width
    localparam int grp_add         = 2;                      // Group index width

    // Host register map
    typedef enum logic [0:0]
    {
        CFG_POL_EN = 1'b0,                                   // Polarity enable mask
        CFG_GRP_EN = 1'b1                                    // Group enable mask
    } cfg_reg_e;

    typedef enum logic [0:0]
    {
        L1_IDLE  = 1'b0,                                     // No group granted
        L1_SERVE = 1'b1                                      // One group owns the grant
    } l1_state_e;

endpackage

// File: pixel_level.sv
/*
 * Round-robin arbiter for one square pixel group
 * Grants one requesting pixel per cycle while enabled, flags group release
 */
module pixel_level
#(
    parameter int group_size = 4,                            // Group side length
    parameter int lvl_add    = 2                             // Local address width
)
(
    input  logic clk_i,
    input  logic rst_i,
    input  logic enable_i,                                   // Grant from level 1
    input  logic [group_size-1:0][group_size-1:0][lib_arbiter_pkg::polarity-1:0] req_i,
    output logic req_o,                                      // Any pixel requesting
    output logic [group_size-1:0][group_size-1:0] gnt_o,     // Registered grant
    output logic [lvl_add-1:0] x_add_o,                      // Row of granted pixel
    output logic [lvl_add-1:0] y_add_o,                      // Column of granted pixel
    output logic active_o,                                   // Grant present
    output logic grp_release_o                               // Nothing left to serve
);
    logic [group_size*group_size-1:0] pix_req;               // Polarity folded per pixel
    logic [group_size*group_size-1:0] eligible;              // Requests open for grant
    logic [group_size*group_size-1:0] gnt_q;                 // Flat grant register
    logic [group_size*group_size-1:0] gnt_next;              // Grant for next cycle
    logic [2*lvl_add-1:0] ptr_q;                             // Round-robin start index
    logic [2*lvl_add-1:0] pick;                              // Chosen pixel index
    logic found;                                             // Some pixel eligible

    always_comb
    begin
        for (int i = 0; i < group_size*group_size; i++)
        begin
            pix_req[i] = |req_i[i / group_size][i % group_size];  // ON or OFF
        end
    end

    // Pixel granted last cycle still holds its level until the edge
    assign eligible = pix_req & ~gnt_q;

    always_comb
    begin
        int idx;
        found    = 1'b0;
        pick     = '0;
        gnt_next = '0;
        for (int i = 0; i < group_size*group_size; i++)
        begin
            idx = (int'(ptr_q) + i) % (group_size*group_size);  // Scan from pointer
            if (!found && eligible[idx])
            begin
                found = 1'b1;
                pick  = idx[2*lvl_add-1:0];
            end
        end
        if (found)
            gnt_next[pick] = 1'b1;                           // One-hot of chosen pixel
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            gnt_q <= '0;
            ptr_q <= '0;
        end
        else
        begin
            gnt_q <= enable_i ? gnt_next : '0;               // Grant only while enabled
            if (enable_i && found)
                ptr_q <= pick + 1'b1;                        // Wraps at group end
        end
    end

    always_ff @(posedge clk_i)
    begin
        x_add_o <= pick[2*lvl_add-1:lvl_add];                // Row part of index
        y_add_o <= pick[lvl_add-1:0];                        // Column part of index
    end

    assign gnt_o         = gnt_q;                            // Row-major flat layout
    assign req_o         = |pix_req;
    assign active_o      = |gnt_q;
    assign grp_release_o = enable_i && !(|eligible);         // Done once nothing else waits

    // A grant is a single pixel and only follows an enabled cycle
    a_gnt_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
        (gnt_q != '0) |-> ($onehot(gnt_q) && $past(enable_i)));

endmodule

// File: pixel_groups_l0.sv
/*
 * Level-0 grouping of the pixel array
 * Masks polarity, splits the array into four groups and merges their grants
 */
module pixel_groups_l0
(
    input  logic clk_i,
    input  logic rst_i,
    input  logic [lib_arbiter_pkg::lvl0_pixels-1:0][lib_arbiter_pkg::lvl0_pixels-1:0]
                 [lib_arbiter_pkg::polarity-1:0] set_i,     // Raw pixel requests
    input  logic [lib_arbiter_pkg::polarity-1:0] pol_en_i,  // Polarity enable mask
    input  logic [lib_arbiter_pkg::const0-1:0][lib_arbiter_pkg::const0-1:0] gnt_top_i,
    output logic [lib_arbiter_pkg::const0-1:0][lib_arbiter_pkg::const0-1:0] req_o,
    output logic [lib_arbiter_pkg::lvl0_pixels-1:0][lib_arbiter_pkg::lvl0_pixels-1:0] gnt_o_0,
    output logic grp_release_o,                              // Release of granted group
    output logic [lib_arbiter_pkg::lvl0_group_size-1:0]
                 [lib_arbiter_pkg::lvl0_group_size-1:0] gnt_o,  // Active group grant
    output logic [lib_arbiter_pkg::lvl0_add-1:0] x_add_o,    // Local row
    output logic [lib_arbiter_pkg::lvl0_add-1:0] y_add_o,    // Local column
    output logic [lib_arbiter_pkg::grp_add-1:0] grp_sel_o,   // Group holding the grant
    output logic [lib_arbiter_pkg::lvl0_pixels-1:0][lib_arbiter_pkg::lvl0_pixels-1:0]
                 [lib_arbiter_pkg::polarity-1:0] set_masked_o
);
    logic [lib_arbiter_pkg::num_groups0-1:0][lib_arbiter_pkg::lvl0_group_size-1:0]
          [lib_arbiter_pkg::lvl0_group_size-1:0][lib_arbiter_pkg::polarity-1:0] set_group;
    logic [lib_arbiter_pkg::num_groups0-1:0][lib_arbiter_pkg::lvl0_group_size-1:0]
          [lib_arbiter_pkg::lvl0_group_size-1:0] gnt_grp;   // Per-group grants
    logic [lib_arbiter_pkg::num_groups0-1:0][lib_arbiter_pkg::lvl0_add-1:0] x_add_grp;
    logic [lib_arbiter_pkg::num_groups0-1:0][lib_arbiter_pkg::lvl0_add-1:0] y_add_grp;
    logic [lib_arbiter_pkg::num_groups0-1:0] active_grp;     // Group has a grant out
    logic [lib_arbiter_pkg::num_groups0-1:0] release_grp;    // Group release flags

    always_comb
    begin
        int r0;
        int c0;
        for (int r = 0; r < lib_arbiter_pkg::lvl0_pixels; r++)
            for (int c = 0; c < lib_arbiter_pkg::lvl0_pixels; c++)
                set_masked_o[r][c] = set_i[r][c] & pol_en_i;     // Drop disabled polarity
        for (int g = 0; g < lib_arbiter_pkg::num_groups0; g++)
        begin
            r0 = (g / lib_arbiter_pkg::const0) * lib_arbiter_pkg::lvl0_group_size;
            c0 = (g % lib_arbiter_pkg::const0) * lib_arbiter_pkg::lvl0_group_size;
            for (int r = 0; r < lib_arbiter_pkg::lvl0_group_size; r++)
                for (int c = 0; c < lib_arbiter_pkg::lvl0_group_size; c++)
                begin
                    set_group[g][r][c]     = set_masked_o[r0+r][c0+c];  // Slice out
                    gnt_o_0[r0+r][c0+c]    = gnt_grp[g][r][c];          // Place back
                end
        end
    end

    for (genvar g = 0; g < lib_arbiter_pkg::num_groups0; g++)
    begin : groups
        pixel_level
        #(
            .group_size (lib_arbiter_pkg::lvl0_group_size),
            .lvl_add    (lib_arbiter_pkg::lvl0_add)
        )
        i_pixel_level
        (
            .clk_i         (clk_i),
            .rst_i         (rst_i),
            .enable_i      (gnt_top_i[g / lib_arbiter_pkg::const0][g % lib_arbiter_pkg::const0]),
            .req_i         (set_group[g]),
            .req_o         (req_o[g / lib_arbiter_pkg::const0][g % lib_arbiter_pkg::const0]),
            .gnt_o         (gnt_grp[g]),
            .x_add_o       (x_add_grp[g]),
            .y_add_o       (y_add_grp[g]),
            .active_o      (active_grp[g]),
            .grp_release_o (release_grp[g])
        );
    end

    // Payload follows the group holding a grant, release follows the enabled group
    always_comb
    begin
        gnt_o         = '0;
        x_add_o       = '0;
        y_add_o       = '0;
        grp_sel_o     = '0;
        grp_release_o = 1'b0;
        for (int g = 0; g < lib_arbiter_pkg::num_groups0; g++)
        begin
            if (active_grp[g])
            begin
                gnt_o     = gnt_grp[g];
                x_add_o   = x_add_grp[g];
                y_add_o   = y_add_grp[g];
                grp_sel_o = g[lib_arbiter_pkg::grp_add-1:0];
            end
            if (gnt_top_i[g / lib_arbiter_pkg::const0][g % lib_arbiter_pkg::const0])
                grp_release_o = release_grp[g];
        end
    end

endmodule

// File: group_arbiter_l1.sv
/*
 * Level-1 group arbiter
 * Round-robin over enabled requesting groups that holds a grant until release
 */
module group_arbiter_l1
(
    input  logic clk_i,
    input  logic rst_i,
    input  logic [lib_arbiter_pkg::const0-1:0][lib_arbiter_pkg::const0-1:0] req_i,
    input  logic [lib_arbiter_pkg::num_groups0-1:0] grp_en_i,   // Group enable mask
    input  logic grp_release_i,                                 // Granted group is done
    output logic [lib_arbiter_pkg::const0-1:0][lib_arbiter_pkg::const0-1:0] gnt_top_o
);
    lib_arbiter_pkg::l1_state_e state_q;                     // IDLE or SERVE
    logic [lib_arbiter_pkg::num_groups0-1:0] eligible;       // Enabled requesting groups
    logic [lib_arbiter_pkg::num_groups0-1:0] gnt_q;          // One-hot group grant
    logic [lib_arbiter_pkg::num_groups0-1:0] gnt_next;
    logic [lib_arbiter_pkg::grp_add-1:0] ptr_q;              // Next group to try first
    logic [lib_arbiter_pkg::grp_add-1:0] pick;
    logic found;
    logic take;                                              // Free to pass the grant on

    // Releasing group may still show its last pixel, so it is skipped
    assign eligible = req_i & grp_en_i & ~gnt_q;
    assign take     = (state_q == lib_arbiter_pkg::L1_IDLE) || grp_release_i;

    always_comb
    begin
        int idx;
        found    = 1'b0;
        pick     = '0;
        gnt_next = '0;
        for (int i = 0; i < lib_arbiter_pkg::num_groups0; i++)
        begin
            idx = (int'(ptr_q) + i) % lib_arbiter_pkg::num_groups0;
            if (!found && eligible[idx])
            begin
                found = 1'b1;
                pick  = idx[lib_arbiter_pkg::grp_add-1:0];
            end
        end
        if (found)
            gnt_next[pick] = 1'b1;
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            state_q <= lib_arbiter_pkg::L1_IDLE;
            gnt_q   <= '0;
            ptr_q   <= '0;
        end
        else if (take)
        begin
            gnt_q   <= gnt_next;                             // Zero when nobody asks
            state_q <= found ? lib_arbiter_pkg::L1_SERVE : lib_arbiter_pkg::L1_IDLE;
            if (found)
                ptr_q <= pick + 1'b1;                        // Start after winner
        end
    end

    assign gnt_top_o = gnt_q;                                // Bit g is row g/2, col g%2

    a_gnt_top: assert property (@(posedge clk_i) disable iff (rst_i)
        $onehot0(gnt_q) && ((state_q == lib_arbiter_pkg::L1_SERVE) == (gnt_q != '0)));

endmodule

// File: arbiter_cfg.sv
/*
 * Host configuration registers
 * Polarity and group enable masks, both reset to all ones
 */
module arbiter_cfg
(
    input  logic clk_i,
    input  logic rst_i,
    input  logic cfg_we_i,                                   // One-cycle write strobe
    input  lib_arbiter_pkg::cfg_reg_e cfg_addr_i,            // Register select
    input  logic [3:0] cfg_wdata_i,
    output logic [lib_arbiter_pkg::polarity-1:0] pol_en_o,   // Bit 1 ON, bit 0 OFF
    output logic [lib_arbiter_pkg::num_groups0-1:0] grp_en_o
);
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            pol_en_o <= '1;                                  // Everything enabled
            grp_en_o <= '1;
        end
        else if (cfg_we_i)
        begin
            case (cfg_addr_i)
                lib_arbiter_pkg::CFG_POL_EN: pol_en_o <= cfg_wdata_i[1:0];
                lib_arbiter_pkg::CFG_GRP_EN: grp_en_o <= cfg_wdata_i;
                default:                     ;               // Unmapped, ignored
            endcase
        end
    end

    a_cfg_addr: assert property (@(posedge clk_i) disable iff (rst_i)
        cfg_we_i |-> (cfg_addr_i inside {lib_arbiter_pkg::CFG_POL_EN,
                                         lib_arbiter_pkg::CFG_GRP_EN}));

endmodule

// File: event_encoder.sv
/*
 * Address-event encoder
 * Registers x, y and polarity of the granted pixel as a one-cycle event
 */
module event_encoder
(
    input  logic clk_i,
    input  logic rst_i,
    input  logic [lib_arbiter_pkg::lvl0_pixels-1:0][lib_arbiter_pkg::lvl0_pixels-1:0] gnt_i,
    input  logic [lib_arbiter_pkg::lvl0_pixels-1:0][lib_arbiter_pkg::lvl0_pixels-1:0]
                 [lib_arbiter_pkg::polarity-1:0] set_i,     // Masked pixel levels
    input  logic [lib_arbiter_pkg::grp_add-1:0] grp_sel_i,   // Group of the grant
    input  logic [lib_arbiter_pkg::lvl0_add-1:0] x_add_i,    // Local row
    input  logic [lib_arbiter_pkg::lvl0_add-1:0] y_add_i,    // Local column
    output logic event_valid_o,
    output logic [lib_arbiter_pkg::full_add-1:0] event_x_o,
    output logic [lib_arbiter_pkg::full_add-1:0] event_y_o,
    output logic event_pol_o                                 // 1 ON, 0 OFF
);
    logic [lib_arbiter_pkg::full_add-1:0] ev_x;              // Full row address
    logic [lib_arbiter_pkg::full_add-1:0] ev_y;              // Full column address

    always_comb
    begin
        int row;
        int col;
        row  = (int'(grp_sel_i) / lib_arbiter_pkg::const0) * lib_arbiter_pkg::lvl0_group_size
               + int'(x_add_i);
        col  = (int'(grp_sel_i) % lib_arbiter_pkg::const0) * lib_arbiter_pkg::lvl0_group_size
               + int'(y_add_i);
        ev_x = row[lib_arbiter_pkg::full_add-1:0];
        ev_y = col[lib_arbiter_pkg::full_add-1:0];
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            event_valid_o <= 1'b0;
        else
            event_valid_o <= |gnt_i;                         // One event per grant
    end

    always_ff @(posedge clk_i)
    begin
        event_x_o   <= ev_x;
        event_y_o   <= ev_y;
        event_pol_o <= set_i[ev_x][ev_y][1];                 // ON wins when both set
    end

    // Rebuilt address must land on the granted pixel, which still requests
    a_addr_match: assert property (@(posedge clk_i) disable iff (rst_i)
        (|gnt_i) |-> (gnt_i[ev_x][ev_y] && (|set_i[ev_x][ev_y])));

endmodule

// File: pixel_arbiter_top.sv
/*
 * Readout arbiter top for the 8x8 event-camera array
 * Ties configuration, both arbiter levels and the event encoder together
 */
module pixel_arbiter_top
(
    input  logic clk_i,
    input  logic rst_i,
    input  logic [lib_arbiter_pkg::lvl0_pixels-1:0][lib_arbiter_pkg::lvl0_pixels-1:0]
                 [lib_arbiter_pkg::polarity-1:0] set_i,     // Pixel request levels
    input  logic cfg_we_i,
    input  lib_arbiter_pkg::cfg_reg_e cfg_addr_i,
    input  logic [3:0] cfg_wdata_i,
    output logic [lib_arbiter_pkg::lvl0_pixels-1:0][lib_arbiter_pkg::lvl0_pixels-1:0] ack_o,
    output logic event_valid_o,
    output logic [lib_arbiter_pkg::full_add-1:0] event_x_o,
    output logic [lib_arbiter_pkg::full_add-1:0] event_y_o,
    output logic event_pol_o
);
    logic [lib_arbiter_pkg::polarity-1:0] pol_en;            // Polarity mask
    logic [lib_arbiter_pkg::num_groups0-1:0] grp_en;         // Group mask
    logic [lib_arbiter_pkg::const0-1:0][lib_arbiter_pkg::const0-1:0] req;
    logic [lib_arbiter_pkg::const0-1:0][lib_arbiter_pkg::const0-1:0] gnt_top;
    logic grp_release;
    logic [lib_arbiter_pkg::lvl0_add-1:0] x_add;
    logic [lib_arbiter_pkg::lvl0_add-1:0] y_add;
    logic [lib_arbiter_pkg::grp_add-1:0] grp_sel;
    logic [lib_arbiter_pkg::lvl0_pixels-1:0][lib_arbiter_pkg::lvl0_pixels-1:0]
          [lib_arbiter_pkg::polarity-1:0] set_masked;

    arbiter_cfg i_arbiter_cfg
    (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .cfg_we_i    (cfg_we_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_wdata_i (cfg_wdata_i),
        .pol_en_o    (pol_en),
        .grp_en_o    (grp_en)
    );

    pixel_groups_l0 i_pixel_groups_l0
    (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .set_i         (set_i),
        .pol_en_i      (pol_en),
        .gnt_top_i     (gnt_top),
        .req_o         (req),
        .gnt_o_0       (ack_o),                              // Merged grant is the ack
        .grp_release_o (grp_release),
        .gnt_o         (),
        .x_add_o       (x_add),
        .y_add_o       (y_add),
        .grp_sel_o     (grp_sel),
        .set_masked_o  (set_masked)
    );

    group_arbiter_l1 i_group_arbiter_l1
    (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .req_i         (req),
        .grp_en_i      (grp_en),
        .grp_release_i (grp_release),
        .gnt_top_o     (gnt_top)
    );

    event_encoder i_event_encoder
    (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .gnt_i         (ack_o),
        .set_i         (set_masked),
        .grp_sel_i     (grp_sel),
        .x_add_i       (x_add),
        .y_add_i       (y_add),
        .event_valid_o (event_valid_o),
        .event_x_o     (event_x_o),
        .event_y_o     (event_y_o),
        .event_pol_o   (event_pol_o)
    );

endmodule

// File: tb_pixel_arbiter.sv
/*
 * Testbench for the event-camera readout arbiter
 * Pixel-array model with LFSR patterns and concurrent checks on acks and events
 */
module tb_pixel_arbiter;

    logic clk;
    logic rst;
    logic [lib_arbiter_pkg::lvl0_pixels-1:0][lib_arbiter_pkg::lvl0_pixels-1:0]
          [lib_arbiter_pkg::polarity-1:0] set_px;              // Latched pixel requests
    logic cfg_we;
    lib_arbiter_pkg::cfg_reg_e cfg_addr;
    logic [3:0] cfg_wdata;
    logic [lib_arbiter_pkg::lvl0_pixels-1:0][lib_arbiter_pkg::lvl0_pixels-1:0] ack;
    logic ev_valid;
    logic [lib_arbiter_pkg::full_add-1:0] ev_x;
    logic [lib_arbiter_pkg::full_add-1:0] ev_y;
    logic ev_pol;

    logic [lib_arbiter_pkg::lvl0_pixels-1:0][lib_arbiter_pkg::lvl0_pixels-1:0] allowed;
    logic [lib_arbiter_pkg::lvl0_pixels-1:0][lib_arbiter_pkg::lvl0_pixels-1:0] served;
    logic [lib_arbiter_pkg::lvl0_pixels-1:0][lib_arbiter_pkg::lvl0_pixels-1:0] ack_prev;
    logic [lib_arbiter_pkg::polarity-1:0] pol_mask;            // Host view of the masks
    logic [lib_arbiter_pkg::num_groups0-1:0] grp_mask;
    logic rst_seen;                                            // Reset seen at last edge
    logic pend_valid;                                          // Event due next cycle
    logic [lib_arbiter_pkg::full_add-1:0] pend_x;
    logic [lib_arbiter_pkg::full_add-1:0] pend_y;
    logic pend_pol;
    logic exp_valid;                                           // Event due this cycle
    logic [lib_arbiter_pkg::full_add-1:0] exp_x;
    logic [lib_arbiter_pkg::full_add-1:0] exp_y;
    logic exp_pol;
    logic [15:0] lfsr;
    int ev_cnt;                                                // Events since drain start
    string test_name;

    pixel_arbiter_top dut0
    (
        .clk_i         (clk),
        .rst_i         (rst),
        .set_i         (set_px),
        .cfg_we_i      (cfg_we),
        .cfg_addr_i    (cfg_addr),
        .cfg_wdata_i   (cfg_wdata),
        .ack_o         (ack),
        .event_valid_o (ev_valid),
        .event_x_o     (ev_x),
        .event_y_o     (ev_y),
        .event_pol_o   (ev_pol)
    );

    initial
        clk = 1'b0;
    always #2 clk = ~clk;                                      // Period 4

    always @(posedge clk)
        rst_seen <= rst;

    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // Pixel may be acked when an enabled polarity is set and its group is enabled
    function automatic logic request_open(input logic [lib_arbiter_pkg::polarity-1:0] px,
                                          input logic [lib_arbiter_pkg::polarity-1:0] pmask,
                                          input logic [lib_arbiter_pkg::num_groups0-1:0] gmask,
                                          input int r, input int c);
        int g;
        g = (r / lib_arbiter_pkg::lvl0_group_size) * lib_arbiter_pkg::const0
            + c / lib_arbiter_pkg::lvl0_group_size;
        return (|(px & pmask)) && gmask[g];
    endfunction

    function automatic int count_open();
        int n;
        n = 0;
        for (int r = 0; r < lib_arbiter_pkg::lvl0_pixels; r++)
            for (int c = 0; c < lib_arbiter_pkg::lvl0_pixels; c++)
                if (request_open(set_px[r][c], pol_mask, grp_mask, r, c))
                    n++;
        return n;
    endfunction

    always_comb
    begin
        for (int r = 0; r < lib_arbiter_pkg::lvl0_pixels; r++)
            for (int c = 0; c < lib_arbiter_pkg::lvl0_pixels; c++)
                allowed[r][c] = request_open(set_px[r][c], pol_mask, grp_mask, r, c);
    end

    task automatic report_mismatch(input string what, input logic [64:0] expected,
                                   input logic [64:0] actual);
        $display("FAILED %s %s expected %0h actual %0h", test_name, what, expected, actual);
        $display("Something failed");
        $fatal(1, "Stopped at first mismatch");
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timeout in %s while waiting for %s", test_name, what);
        $display("Something failed");
        $fatal(1, "Stopped on timeout");
    endtask

    // Acked pixels drop on the falling edge one cycle after their ack
    task automatic tick();
        @(negedge clk);
        if (ev_valid)
            ev_cnt++;
        exp_valid  = pend_valid;                               // Shift expectation stage
        exp_x      = pend_x;
        exp_y      = pend_y;
        exp_pol    = pend_pol;
        pend_valid = 1'b0;
        for (int r = 0; r < lib_arbiter_pkg::lvl0_pixels; r++)
            for (int c = 0; c < lib_arbiter_pkg::lvl0_pixels; c++)
            begin
                if (ack[r][c])
                begin
                    pend_valid = 1'b1;
                    pend_x     = r[lib_arbiter_pkg::full_add-1:0];
                    pend_y     = c[lib_arbiter_pkg::full_add-1:0];
                    pend_pol   = set_px[r][c][1] & pol_mask[1];  // ON has priority
                end
                if (ack_prev[r][c])
                    set_px[r][c] = '0;
            end
        served   = served | ack_prev;
        ack_prev = ack;
    endtask

    task automatic write_cfg(input lib_arbiter_pkg::cfg_reg_e addr, input logic [3:0] data);
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        if (addr == lib_arbiter_pkg::CFG_POL_EN)
            pol_mask = data[lib_arbiter_pkg::polarity-1:0];
        else
            grp_mask = data;
        tick();
        cfg_we = 1'b0;
        tick();
    endtask

    task automatic load_random_pattern();
        served = '0;
        for (int r = 0; r < lib_arbiter_pkg::lvl0_pixels; r++)
            for (int c = 0; c < lib_arbiter_pkg::lvl0_pixels; c++)
                for (int p = 0; p < lib_arbiter_pkg::polarity; p++)
                begin
                    lfsr            = lfsr_step(lfsr);
                    set_px[r][c][p] = lfsr[0];
                end
    endtask

    task automatic drain_requests();
        int cycles;
        int expected;
        cycles   = 0;
        ev_cnt   = 0;
        expected = count_open();                               // One event per open pixel
        while (count_open() != 0 && cycles < 2000)
        begin
            tick();
            cycles++;
        end
        if (count_open() != 0)
            abort_on_timeout("open requests to drain");
        repeat (4) tick();                                     // Last event and L1 idle
        a_event_count: assert (ev_cnt == expected)
        else
            report_mismatch("event count", expected, ev_cnt);
    endtask

    a_reset_quiet: assert property (@(posedge clk) rst_seen |-> (ack == '0 && !ev_valid))
    else
        report_mismatch("ack_o and event_valid_o", 0, {$sampled(ack), $sampled(ev_valid)});

    a_ack_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(ack))
    else
        report_mismatch("ack_o bits set", 1, $countones($sampled(ack)));

    a_valid: assert property (@(posedge clk) disable iff (rst) ev_valid == exp_valid)
    else
        report_mismatch("event_valid_o", exp_valid, $sampled(ev_valid));

    a_event_x: assert property (@(posedge clk) disable iff (rst) exp_valid |-> ev_x == exp_x)
    else
        report_mismatch("event_x_o", exp_x, $sampled(ev_x));

    a_event_y: assert property (@(posedge clk) disable iff (rst) exp_valid |-> ev_y == exp_y)
    else
        report_mismatch("event_y_o", exp_y, $sampled(ev_y));

    a_event_pol: assert property (@(posedge clk) disable iff (rst)
        exp_valid |-> ev_pol == exp_pol)
    else
        report_mismatch("event_pol_o", exp_pol, $sampled(ev_pol));

    // Masked polarity, disabled group or idle pixel never gets an ack
    a_ack_allowed: assert property (@(posedge clk) disable iff (rst) (ack & ~allowed) == '0)
    else
        report_mismatch("ack_o outside open requests", 0, $sampled(ack & ~allowed));

    a_ack_once: assert property (@(posedge clk) disable iff (rst) (ack & served) == '0)
    else
        report_mismatch("ack_o repeated", 0, $sampled(ack & served));

    initial
    begin
        rst        = 1'b1;
        rst_seen   = 1'b0;
        set_px     = '0;
        cfg_we     = 1'b0;
        cfg_addr   = lib_arbiter_pkg::CFG_POL_EN;
        cfg_wdata  = '0;
        pol_mask   = '1;                                       // Reset value of both masks
        grp_mask   = '1;
        served     = '0;
        ack_prev   = '0;
        pend_valid = 1'b0;
        exp_valid  = 1'b0;
        lfsr       = 16'd15;
        ev_cnt     = 0;
        test_name  = "reset_state";
        repeat (16) tick();
        rst = 1'b0;
        repeat (4) tick();

        test_name = "random_drain";
        repeat (4)
        begin
            load_random_pattern();
            drain_requests();
        end

        test_name = "polarity_mask";
        write_cfg(lib_arbiter_pkg::CFG_POL_EN, 4'b0010);       // OFF disabled
        load_random_pattern();
        drain_requests();
        write_cfg(lib_arbiter_pkg::CFG_POL_EN, 4'b0011);       // OFF-only pixels now served
        drain_requests();
        write_cfg(lib_arbiter_pkg::CFG_POL_EN, 4'b0001);       // ON disabled so every event is OFF
        load_random_pattern();
        drain_requests();
        write_cfg(lib_arbiter_pkg::CFG_POL_EN, 4'b0011);
        drain_requests();

        test_name = "group_mask";
        write_cfg(lib_arbiter_pkg::CFG_GRP_EN, 4'b1101);       // Group 1 parked
        load_random_pattern();
        drain_requests();
        write_cfg(lib_arbiter_pkg::CFG_GRP_EN, 4'b1111);
        drain_requests();
        write_cfg(lib_arbiter_pkg::CFG_GRP_EN, 4'b0110);       // Groups 0 and 3 parked
        load_random_pattern();
        drain_requests();
        write_cfg(lib_arbiter_pkg::CFG_GRP_EN, 4'b1111);
        drain_requests();

        $display("Everything OK");
        $finish;
    end

endmodule

// File: build.f
lib_arbiter_pkg.sv
pixel_level.sv
pixel_groups_l0.sv
group_arbiter_l1.sv
arbiter_cfg.sv
event_encoder.sv
pixel_arbiter_top.sv
tb_pixel_arbiter.sv
